// ==== Makefile ====
# Verilator flow for the dual-clock FIFO
# Any variable below can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= tb_async_fifo
RTL_TOP    ?= async_fifo
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= sim passed
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter hdl/%,$(SRCS))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation PASSED"; \
	else \
	  echo "Simulation FAILED"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
hdl/cdc_fifo_pkg.sv
hdl/gray_sync.sv
hdl/fifo_mem.sv
hdl/wr_ptr_ctrl.sv
hdl/rd_ptr_ctrl.sv
hdl/async_fifo.sv
tests/tb_clk_gen.sv
tests/tb_async_fifo.sv

// ==== hdl/async_fifo.sv ====
`default_nettype none

module async_fifo #(
  parameter int unsigned afull_level  = 15,
  parameter int unsigned aempty_level = 1
) (
  input  logic                wr_clk,
  input  logic                rd_clk,
  input  logic                wr_rst_n,
  input  logic                wr_en,
  input  cdc_fifo_pkg::data_t wr_data,
  input  logic                rd_en,
  output cdc_fifo_pkg::data_t rd_data,
  output logic                full,
  output logic                afull,
  output logic                empty,
  output logic                aempty
);

  import cdc_fifo_pkg::*;

  // Write domain
  logic  wr_rst_sync_n;
  logic  mem_wr_en;
  addr_t mem_wr_addr;
  ptr_t  wr_gray;
  ptr_t  rd_ptr_wsync;

  // Read domain
  logic  rd_rst_sync_n;
  logic  mem_rd_en;
  addr_t mem_rd_addr;
  ptr_t  rd_gray;
  ptr_t  wr_ptr_rsync;

  wr_ptr_ctrl #(
    .afull_level (afull_level)
  ) u_wr_ptr_ctrl (
    .wr_clk        (wr_clk),
    .wr_rst_n      (wr_rst_n),
    .wr_en         (wr_en),
    .rd_ptr_wsync  (rd_ptr_wsync),
    .mem_wr_en     (mem_wr_en),
    .mem_wr_addr   (mem_wr_addr),
    .wr_gray       (wr_gray),
    .full          (full),
    .afull         (afull),
    .wr_rst_sync_n (wr_rst_sync_n)
  );

  // Write pointer into the read domain
  gray_sync u_wr_to_rd_sync (
    .clk     (rd_clk),
    .rst_n   (rd_rst_sync_n),
    .gray_in (wr_gray),
    .bin_out (wr_ptr_rsync)
  );

  // Read pointer back into the write domain
  gray_sync u_rd_to_wr_sync (
    .clk     (wr_clk),
    .rst_n   (wr_rst_sync_n),
    .gray_in (rd_gray),
    .bin_out (rd_ptr_wsync)
  );

  rd_ptr_ctrl #(
    .aempty_level (aempty_level)
  ) u_rd_ptr_ctrl (
    .rd_clk        (rd_clk),
    .wr_rst_n      (wr_rst_n),
    .rd_en         (rd_en),
    .wr_ptr_rsync  (wr_ptr_rsync),
    .mem_rd_en     (mem_rd_en),
    .mem_rd_addr   (mem_rd_addr),
    .rd_gray       (rd_gray),
    .empty         (empty),
    .aempty        (aempty),
    .rd_rst_sync_n (rd_rst_sync_n)
  );

  fifo_mem u_fifo_mem (
    .wr_clk  (wr_clk),
    .wr_en   (mem_wr_en),
    .wr_addr (mem_wr_addr),
    .wr_data (wr_data),
    .rd_clk  (rd_clk),
    .rd_en   (mem_rd_en),
    .rd_addr (mem_rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// ==== hdl/cdc_fifo_pkg.sv ====
`default_nettype none

package cdc_fifo_pkg;

  // Sample width carried across the clock boundary
  localparam int fifo_data_w = 8;

  // Memory address width, the pointers carry one extra wrap bit on top
  localparam int fifo_addr_w = 4;

  localparam int fifo_depth = 1 << fifo_addr_w;  // Sixteen entries

  // One sample as stored in the memory
  typedef logic [fifo_data_w-1:0] data_t;

  // Index into the sample memory
  typedef logic [fifo_addr_w-1:0] addr_t;

  // Pointer with wrap bit, binary or Gray coded
  // Also wide enough for a fill count from 0 up to fifo_depth
  typedef logic [fifo_addr_w:0] ptr_t;

endpackage

`default_nettype wire

// ==== hdl/fifo_mem.sv ====
`default_nettype none

module fifo_mem (
  input  logic                wr_clk,
  input  logic                wr_en,
  input  cdc_fifo_pkg::addr_t wr_addr,
  input  cdc_fifo_pkg::data_t wr_data,
  input  logic                rd_clk,
  input  logic                rd_en,
  input  cdc_fifo_pkg::addr_t rd_addr,
  output cdc_fifo_pkg::data_t rd_data
);

  import cdc_fifo_pkg::*;

  data_t mem [fifo_depth];

  // Write port in the producer domain
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port, the output holds between accepted reads
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/gray_sync.sv ====
`default_nettype none

module gray_sync (
  input  logic               clk,
  input  logic               rst_n,
  input  cdc_fifo_pkg::ptr_t gray_in,
  output cdc_fifo_pkg::ptr_t bin_out
);

  import cdc_fifo_pkg::*;

  // First stage may go metastable, the second one settles it
  ptr_t gray_meta;
  ptr_t gray_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gray_meta <= '0;
      gray_q    <= '0;
    end else begin
      gray_meta <= gray_in;   // Only one bit changes per source step
      gray_q    <= gray_meta;
    end
  end

  // Each binary bit is the parity of the Gray bits from the top down to it
  always_comb begin
    for (int i = 0; i <= fifo_addr_w; i++) begin
      bin_out[i] = ^(gray_q >> i);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rd_ptr_ctrl.sv ====
`default_nettype none

module rd_ptr_ctrl #(
  parameter int unsigned aempty_level = 1
) (
  input  logic                rd_clk,
  input  logic                wr_rst_n,
  input  logic                rd_en,
  input  cdc_fifo_pkg::ptr_t  wr_ptr_rsync,
  output logic                mem_rd_en,
  output cdc_fifo_pkg::addr_t mem_rd_addr,
  output cdc_fifo_pkg::ptr_t  rd_gray,
  output logic                empty,
  output logic                aempty,
  output logic                rd_rst_sync_n
);

  import cdc_fifo_pkg::*;

  logic [1:0] rst_pipe;
  logic       rd_accept;
  ptr_t       rd_bin;
  ptr_t       rd_bin_nxt;
  ptr_t       rd_gray_nxt;
  ptr_t       fill_nxt;

  // The shared reset input is released into rd_clk separately
  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rst_pipe <= '0;
    end else begin
      rst_pipe <= {rst_pipe[0], 1'b1};
    end
  end

  assign rd_rst_sync_n = rst_pipe[1];

  assign rd_accept   = rd_en && !empty;  // Reads from an empty FIFO are ignored
  assign rd_bin_nxt  = rd_bin + ptr_t'(rd_accept);
  assign rd_gray_nxt = (rd_bin_nxt >> 1) ^ rd_bin_nxt;

  // Fill level as seen from the read side, never above the true level
  assign fill_nxt = wr_ptr_rsync - rd_bin_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_sync_n) begin
    if (!rd_rst_sync_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
      empty   <= 1'b1;
      aempty  <= 1'b1;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
      empty   <= (rd_bin_nxt == wr_ptr_rsync);
      aempty  <= (fill_nxt <= ptr_t'(aempty_level));
    end
  end

  // Memory is read from the slot of the current pointer
  // The sample lands in rd_data at the same edge the pointer moves on
  assign mem_rd_en   = rd_accept;
  assign mem_rd_addr = rd_bin[fifo_addr_w-1:0];

endmodule

`default_nettype wire

// ==== hdl/wr_ptr_ctrl.sv ====
`default_nettype none

module wr_ptr_ctrl #(
  parameter int unsigned afull_level = 15
) (
  input  logic                wr_clk,
  input  logic                wr_rst_n,
  input  logic                wr_en,
  input  cdc_fifo_pkg::ptr_t  rd_ptr_wsync,
  output logic                mem_wr_en,
  output cdc_fifo_pkg::addr_t mem_wr_addr,
  output cdc_fifo_pkg::ptr_t  wr_gray,
  output logic                full,
  output logic                afull,
  output logic                wr_rst_sync_n
);

  import cdc_fifo_pkg::*;

  logic [1:0] rst_pipe;
  logic       wr_accept;
  ptr_t       wr_bin;
  ptr_t       wr_bin_nxt;
  ptr_t       wr_gray_nxt;
  ptr_t       fill_nxt;

  // Reset asserts at once and is released on the second wr_clk edge
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rst_pipe <= '0;
    end else begin
      rst_pipe <= {rst_pipe[0], 1'b1};
    end
  end

  assign wr_rst_sync_n = rst_pipe[1];

  assign wr_accept   = wr_en && !full;  // Writes into a full FIFO are dropped
  assign wr_bin_nxt  = wr_bin + ptr_t'(wr_accept);
  assign wr_gray_nxt = (wr_bin_nxt >> 1) ^ wr_bin_nxt;

  // The binary form of the next Gray pointer is wr_bin_nxt itself
  // The read pointer lags, so this count can only overstate the fill
  assign fill_nxt = wr_bin_nxt - rd_ptr_wsync;

  always_ff @(posedge wr_clk or negedge wr_rst_sync_n) begin
    if (!wr_rst_sync_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
      full    <= 1'b0;
      afull   <= 1'b0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt;
      full    <= (fill_nxt == ptr_t'(fifo_depth));
      afull   <= (fill_nxt >= ptr_t'(afull_level));
    end
  end

  // The sample goes to the slot of the current pointer
  assign mem_wr_en   = wr_accept;
  assign mem_wr_addr = wr_bin[fifo_addr_w-1:0];

endmodule

`default_nettype wire

// ==== tests/tb_async_fifo.sv ====
`default_nettype none

module tb_async_fifo;

  import cdc_fifo_pkg::*;

  localparam int unsigned afull_level  = 15;
  localparam int unsigned aempty_level = 1;

  // Test lengths counted in wr_clk cycles, the slower clock
  localparam int reset_len     = 10;
  localparam int fill_len      = 40;
  localparam int drain_len     = 90;
  localparam int level_len     = 120;
  localparam int random_len    = 2100;
  localparam int all_len       = reset_len + fill_len + drain_len + level_len + random_len;
  localparam int watchdog_time = all_len * 6 * 2;
  localparam int drain_max     = 64;  // rd_clk cycles allowed for one drain

  logic  wr_clk;
  logic  rd_clk;
  logic  wr_rst_n;
  logic  wr_en;
  data_t wr_data;
  logic  rd_en;
  data_t rd_data;
  logic  full;
  logic  afull;
  logic  empty;
  logic  aempty;

  // Read that the compare process expects at the next rd_clk edge
  logic  rd_chk;
  data_t rd_exp;

  data_t       model_q[$];
  logic [31:0] lfsr_state;
  string       cur_test;
  int          n_tests;
  int          n_checks;
  int          n_errors;
  int          test_checks0;
  int          test_errors0;

  tb_clk_gen #(.period(4)) u_rd_clk_gen (.clk(rd_clk));
  tb_clk_gen #(.period(6)) u_wr_clk_gen (.clk(wr_clk));

  async_fifo #(
    .afull_level  (afull_level),
    .aempty_level (aempty_level)
  ) dut (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r          = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic int model_fill();
    return model_q.size();
  endfunction

  // Oldest sample of the model, taken out for an accepted read
  function automatic data_t expected_read();
    return model_q.pop_front();
  endfunction

  task automatic check_data(input string what, input data_t want, input data_t got);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("FAILED %s %s: expected 0x%02h, actual 0x%02h", cur_test, what, want, got);
    end
  endtask

  task automatic check_flag(input string what, input logic want, input logic got);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("FAILED %s %s: expected %b, actual %b", cur_test, what, want, got);
    end
  endtask

  task automatic report_error(input string msg);
    n_errors++;
    $display("ERROR %s: %s", cur_test, msg);
  endtask

  task automatic start_test(input string name);
    cur_test     = name;
    test_checks0 = n_checks;
    test_errors0 = n_errors;
  endtask

  task automatic end_test();
    n_tests++;
    $display("test %s: %0d checks, %0d errors", cur_test,
             n_checks - test_checks0, n_errors - test_errors0);
  endtask

  // Called one unit after a wr_clk edge, when full is settled
  task automatic drive_write(input logic en);
    wr_en   = en;
    wr_data = data_t'(lfsr_bits(fifo_data_w));
    if (en && !full) begin
      model_q.push_back(wr_data);
      if (model_fill() > fifo_depth) report_error("model holds more than 16 samples");
    end
  endtask

  task automatic drive_read(input logic en);
    rd_en  = en;
    rd_chk = 1'b0;
    if (en && !empty) begin
      if (model_fill() == 0) begin
        report_error("DUT accepted a read while the model was empty");
      end else begin
        rd_exp = expected_read();
        rd_chk = 1'b1;
      end
    end
  endtask

  // Only with the read side idle and settled is full exact
  task automatic write_burst(input int n);
    repeat (n) begin
      @(posedge wr_clk);
      #1;
      check_flag("full", model_fill() == fifo_depth, full);
      drive_write(1'b1);
    end
    @(posedge wr_clk);
    #1;
    check_flag("full", model_fill() == fifo_depth, full);
    drive_write(1'b0);
  endtask

  task automatic read_burst(input int n);
    repeat (n) begin
      @(posedge rd_clk);
      #1;
      check_flag("empty", model_fill() == 0, empty);
      drive_read(1'b1);
    end
    @(posedge rd_clk);
    #1;
    check_flag("empty", model_fill() == 0, empty);
    drive_read(1'b0);
  endtask

  task automatic drain(input int extra_reads);
    int cycles;
    int extras;
    cycles = 0;
    extras = 0;
    while (extras <= extra_reads && cycles < drain_max) begin
      @(posedge rd_clk);
      #1;
      check_flag("empty", model_fill() == 0, empty);
      if (empty) extras++;
      drive_read(extras <= extra_reads);  // Reads go on past empty, then stop
      cycles++;
    end
    if (extras <= extra_reads) begin
      report_error("FIFO did not run empty during the drain");
      drive_read(1'b0);
    end
  endtask

  // With no traffic both synchronizers settle and all four flags follow the count
  task automatic settle_and_check_levels();
    repeat (10) @(posedge wr_clk);
    #1;
    check_flag("afull", model_fill() >= afull_level, afull);
    check_flag("aempty", model_fill() <= aempty_level, aempty);
    check_flag("full", model_fill() == fifo_depth, full);
    check_flag("empty", model_fill() == 0, empty);
  endtask

  task automatic random_traffic(input int cycles);
    logic [31:0] wr_rnd;
    logic [31:0] rd_rnd;
    fork
      begin
        for (int i = 0; i < cycles; i++) begin
          @(posedge wr_clk);
          #1;
          wr_rnd = lfsr_bits(1);
          drive_write(wr_rnd[0]);
        end
        @(posedge wr_clk);
        #1;
        drive_write(1'b0);
      end
      begin
        for (int i = 0; i < cycles; i++) begin
          @(posedge rd_clk);
          #1;
          rd_rnd = lfsr_bits(2);
          // Sparse reads first so the FIFO fills up, dense reads later
          if (i < cycles / 2) begin
            drive_read(rd_rnd[0] & rd_rnd[1]);
          end else begin
            drive_read(rd_rnd[0] | rd_rnd[1]);
          end
        end
        @(posedge rd_clk);
        #1;
        drive_read(1'b0);
      end
    join
  endtask

  // The sample of an accepted read sits on rd_data one rd_clk edge later
  initial begin : compare_reads
    logic  due;
    data_t want;
    data_t last;
    logic  have_last;
    have_last = 1'b0;
    last      = '0;
    forever begin
      @(posedge rd_clk);
      due  = rd_chk;
      want = rd_exp;
      #2;
      if (due) begin
        check_data("rd_data", want, rd_data);
        last      = rd_data;
        have_last = 1'b1;
      end else if (have_last) begin
        check_data("rd_data held", last, rd_data);  // No accepted read, so no change
      end
    end
  end

  initial begin
    #(watchdog_time);
    $display("Timeout: the tests did not finish within %0d time units", watchdog_time);
    $display("sim failed");
    $finish;
  end

  initial begin
    wr_rst_n   = 1'b0;
    wr_en      = 1'b0;
    wr_data    = '0;
    rd_en      = 1'b0;
    rd_chk     = 1'b0;
    rd_exp     = '0;
    lfsr_state = 32'h1dfc;
    cur_test   = "";
    n_tests    = 0;
    n_checks   = 0;
    n_errors   = 0;

    start_test("reset_values");
    repeat (5) @(posedge rd_clk);
    #1;
    // The flags still hold their reset values here
    check_flag("empty in reset", 1'b1, empty);
    check_flag("aempty in reset", 1'b1, aempty);
    check_flag("full in reset", 1'b0, full);
    check_flag("afull in reset", 1'b0, afull);
    wr_rst_n = 1'b1;
    repeat (4) @(posedge wr_clk);  // Both internal reset synchronizers have let go by now
    #1;
    check_flag("empty", 1'b1, empty);
    check_flag("aempty", 1'b1, aempty);
    check_flag("full", 1'b0, full);
    check_flag("afull", 1'b0, afull);
    end_test();

    start_test("fill_overflow");
    write_burst(20);
    if (model_fill() != fifo_depth) report_error("writes were not accepted up to 16");
    settle_and_check_levels();
    end_test();

    start_test("drain_order");
    drain(4);
    settle_and_check_levels();
    end_test();

    start_test("threshold_flags");
    write_burst(1);
    settle_and_check_levels();
    write_burst(14);
    settle_and_check_levels();
    read_burst(13);
    settle_and_check_levels();
    end_test();

    start_test("random_traffic");
    random_traffic(2000);
    settle_and_check_levels();
    drain(2);
    settle_and_check_levels();
    end_test();

    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen #(
  parameter int period = 4
) (
  output logic clk
);

  // Free running, the first rising edge comes after half a period
  initial begin
    clk = 1'b0;
    forever begin
      #(period / 2) clk = ~clk;
    end
  end

endmodule

`default_nettype wire
